// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_mmu
FILELIST  := compile.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
logic/mmu_pkg.sv
logic/mmu_ifs.sv
logic/tlb.sv
logic/ptw.sv
logic/mmu.sv
verification/tb_pt_mem.sv
verification/tb_mmu.sv

// ==== logic/mmu.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmu import mmu_pkg::*; #(
    parameter int TLB_ENTRIES = 4,
    parameter int MEM_CREDITS = 2
) (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic [PPN_W-1:0] satp_ppn_i,
    input  logic             i_xlate_en_i,
    input  logic             d_xlate_en_i,
    input  logic             tlb_flush_i,
    input  logic             i_req_i,
    input  logic [VA_W-1:0]  i_vaddr_i,
    output logic [PA_W-1:0]  i_paddr_o,
    output logic             i_hit_o,
    output logic             i_fault_o,
    input  logic             d_req_i,
    input  logic             d_store_i,
    input  logic [VA_W-1:0]  d_vaddr_i,
    output logic [PA_W-1:0]  d_paddr_o,
    output logic             d_hit_o,
    output logic             d_fault_o,
    output logic             mem_req_o,
    output logic [PA_W-1:0]  mem_addr_o,
    input  logic             mem_rsp_i,
    input  logic [31:0]      mem_rdata_i,
    input  logic             mem_credit_i
);

    tlb_lookup_if itlb_lu ();
    tlb_lookup_if dtlb_lu ();
    tlb_refill_if itlb_rf ();
    tlb_refill_if dtlb_rf ();

    logic i_perm_ok, d_perm_ok;
    logic i_miss, d_miss;

    assign itlb_lu.req   = i_req_i;
    assign itlb_lu.vpn   = i_vaddr_i[VA_W-1:PAGE_OFFSET_W];
    assign itlb_lu.flush = tlb_flush_i;
    assign dtlb_lu.req   = d_req_i;
    assign dtlb_lu.vpn   = d_vaddr_i[VA_W-1:PAGE_OFFSET_W];
    assign dtlb_lu.flush = tlb_flush_i;

    tlb #(.TLB_ENTRIES(TLB_ENTRIES)) itlb_i (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .lookup_if (itlb_lu),
        .refill_if (itlb_rf)
    );

    tlb #(.TLB_ENTRIES(TLB_ENTRIES)) dtlb_i (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .lookup_if (dtlb_lu),
        .refill_if (dtlb_rf)
    );

    // A hit without the needed permission goes to the walker, which faults it
    assign i_perm_ok = itlb_lu.hit && itlb_lu.perm_x;
    assign d_perm_ok = dtlb_lu.hit && (d_store_i ? dtlb_lu.perm_w : dtlb_lu.perm_r);
    assign i_miss    = i_xlate_en_i && i_req_i && !i_perm_ok;
    assign d_miss    = d_xlate_en_i && d_req_i && !d_perm_ok;

    always_comb begin
        // Bare mode by default
        i_paddr_o = {2'b00, i_vaddr_i};
        i_hit_o   = i_req_i;
        if (i_xlate_en_i) begin
            i_paddr_o = {itlb_lu.ppn, i_vaddr_i[PAGE_OFFSET_W-1:0]};
            i_hit_o   = i_perm_ok;
            if (itlb_lu.superpage) i_paddr_o[21:12] = i_vaddr_i[21:12];
        end
    end

    always_comb begin
        d_paddr_o = {2'b00, d_vaddr_i};
        d_hit_o   = d_req_i;
        if (d_xlate_en_i) begin
            d_paddr_o = {dtlb_lu.ppn, d_vaddr_i[PAGE_OFFSET_W-1:0]};
            d_hit_o   = d_perm_ok;
            // 4 MiB page keeps VA[21:12]
            if (dtlb_lu.superpage) d_paddr_o[21:12] = d_vaddr_i[21:12];
        end
    end

    ptw #(.MEM_CREDITS(MEM_CREDITS)) ptw_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .satp_ppn_i   (satp_ppn_i),
        .i_miss_i     (i_miss),
        .i_vpn_i      (itlb_lu.vpn),
        .d_miss_i     (d_miss),
        .d_vpn_i      (dtlb_lu.vpn),
        .d_store_i    (d_store_i),
        .flush_i      (tlb_flush_i),
        .itlb_refill  (itlb_rf),
        .dtlb_refill  (dtlb_rf),
        .i_fault_o    (i_fault_o),
        .d_fault_o    (d_fault_o),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_rsp_i    (mem_rsp_i),
        .mem_rdata_i  (mem_rdata_i),
        .mem_credit_i (mem_credit_i)
    );

endmodule

`default_nettype wire

// ==== logic/mmu_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// Combinational TLB lookup with hit valid in the cycle of req
interface tlb_lookup_if import mmu_pkg::*; ();
    logic             req;
    logic [VPN_W-1:0] vpn;
    logic             flush;
    logic             hit;
    logic [PPN_W-1:0] ppn;
    logic             superpage;
    logic             perm_r;
    logic             perm_w;
    logic             perm_x;

    modport requester (output req, vpn, flush,
                       input  hit, ppn, superpage, perm_r, perm_w, perm_x);
    modport responder (input  req, vpn, flush,
                       output hit, ppn, superpage, perm_r, perm_w, perm_x);
endinterface

// Refill from the walker with write driven in PTW_REFILL only
interface tlb_refill_if import mmu_pkg::*; ();
    logic             write;
    logic [VPN_W-1:0] vpn;
    logic [PPN_W-1:0] ppn;
    logic             superpage;
    logic             perm_r;
    logic             perm_w;
    logic             perm_x;

    modport writer (output write, vpn, ppn, superpage, perm_r, perm_w, perm_x);
    modport reader (input  write, vpn, ppn, superpage, perm_r, perm_w, perm_x);
endinterface

`default_nettype wire

// ==== logic/mmu_pkg.sv ====
`default_nettype none

package mmu_pkg;

    // Sv32 address widths
    localparam int VA_W          = 32;
    localparam int PA_W          = 34;
    localparam int VPN_W         = 20;
    localparam int PPN_W         = 22;
    localparam int PAGE_OFFSET_W = 12;

    // One Sv32 page-table entry, as it sits in memory
    typedef struct packed {
        logic [PPN_W-1:0] ppn;
        logic [1:0]       rsw;
        logic             d;
        logic             a;
        logic             g;
        logic             u;
        logic             x;
        logic             w;
        logic             r;
        logic             v;
    } pte_t;

    // Cached translation
    typedef struct packed {
        logic             valid;
        logic [VPN_W-1:0] vpn;
        logic             superpage;
        logic [PPN_W-1:0] ppn;
        logic             r;
        logic             w;
        logic             x;
    } tlb_entry_t;

    // Walker states with arbitration in PTW_IDLE
    typedef enum logic [2:0] {
        PTW_IDLE,
        PTW_L1_REQ,
        PTW_L1_WAIT,
        PTW_L0_REQ,
        PTW_L0_WAIT,
        PTW_REFILL,
        PTW_FAULT
    } ptw_state_t;

endpackage

`default_nettype wire

// ==== logic/ptw.sv ====
`timescale 1ns/1ps
`default_nettype none

module ptw import mmu_pkg::*; #(
    parameter int MEM_CREDITS = 2
) (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic [PPN_W-1:0] satp_ppn_i,
    input  logic             i_miss_i,
    input  logic [VPN_W-1:0] i_vpn_i,
    input  logic             d_miss_i,
    input  logic [VPN_W-1:0] d_vpn_i,
    input  logic             d_store_i,
    input  logic             flush_i,
    tlb_refill_if.writer     itlb_refill,
    tlb_refill_if.writer     dtlb_refill,
    output logic             i_fault_o,
    output logic             d_fault_o,
    output logic             mem_req_o,
    output logic [PA_W-1:0]  mem_addr_o,
    input  logic             mem_rsp_i,
    input  logic [31:0]      mem_rdata_i,
    input  logic             mem_credit_i
);

    localparam int CRED_W    = $clog2(MEM_CREDITS + 1);
    localparam int VPN_IDX_W = VPN_W / 2;

    ptw_state_t       state_q, state_d;
    logic [CRED_W-1:0] credits_q;
    logic             flush_q;
    logic             abandon;

    // Latched request and walk result
    logic [VPN_W-1:0] req_vpn;
    logic             req_data;
    logic             req_store;
    logic [PPN_W-1:0] walk_ppn;
    logic             walk_super;
    logic             walk_r, walk_w, walk_x;

    pte_t pte;
    logic pte_bad, pte_leaf, perm_ok;

    assign pte      = pte_t'(mem_rdata_i);
    assign pte_bad  = !pte.v || (pte.w && !pte.r);
    assign pte_leaf = pte.r || pte.x;
    assign perm_ok  = req_data ? (req_store ? pte.w : pte.r) : pte.x;
    assign abandon  = flush_q || flush_i;

    always_comb begin
        mem_req_o  = 1'b0;
        mem_addr_o = {walk_ppn, req_vpn[VPN_IDX_W-1:0], 2'b00};
        if (state_q == PTW_L1_REQ) begin
            mem_req_o  = credits_q != '0;
            mem_addr_o = {satp_ppn_i, req_vpn[VPN_W-1:VPN_IDX_W], 2'b00};
        end else if (state_q == PTW_L0_REQ) begin
            mem_req_o  = credits_q != '0;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            PTW_IDLE:    if (d_miss_i || i_miss_i) state_d = PTW_L1_REQ;
            PTW_L1_REQ:  if (mem_req_o) state_d = PTW_L1_WAIT;
            PTW_L1_WAIT: begin
                if (mem_rsp_i) begin
                    if (abandon) state_d = PTW_IDLE;
                    else if (pte_bad) state_d = PTW_FAULT;
                    else if (!pte_leaf) state_d = PTW_L0_REQ;
                    // Misaligned superpage or missing permission
                    else if (pte.ppn[VPN_IDX_W-1:0] != '0 || !perm_ok) state_d = PTW_FAULT;
                    else state_d = PTW_REFILL;
                end
            end
            PTW_L0_REQ:  if (mem_req_o) state_d = PTW_L0_WAIT;
            PTW_L0_WAIT: begin
                if (mem_rsp_i) begin
                    if (abandon) state_d = PTW_IDLE;
                    else if (pte_bad || !pte_leaf || !perm_ok) state_d = PTW_FAULT;
                    else state_d = PTW_REFILL;
                end
            end
            default:     state_d = PTW_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= PTW_IDLE;
            credits_q <= CRED_W'(MEM_CREDITS);
            flush_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            case ({mem_req_o, mem_credit_i})
                2'b10:   credits_q <= credits_q - 1'b1;
                2'b01:   credits_q <= credits_q + 1'b1;
                default: credits_q <= credits_q;
            endcase
            // Remember a flush until the walk ends
            if (state_q == PTW_IDLE || state_d == PTW_IDLE) flush_q <= 1'b0;
            else if (flush_i) flush_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == PTW_IDLE && (d_miss_i || i_miss_i)) begin
            // Data side has priority
            req_data  <= d_miss_i;
            req_store <= d_miss_i && d_store_i;
            req_vpn   <= d_miss_i ? d_vpn_i : i_vpn_i;
        end
        if (mem_rsp_i && (state_q == PTW_L1_WAIT || state_q == PTW_L0_WAIT)) begin
            walk_ppn   <= pte.ppn;
            walk_super <= state_q == PTW_L1_WAIT;
            walk_r     <= pte.r;
            walk_w     <= pte.w;
            walk_x     <= pte.x;
        end
    end

    assign i_fault_o = (state_q == PTW_FAULT) && !req_data;
    assign d_fault_o = (state_q == PTW_FAULT) && req_data;

    assign itlb_refill.write     = (state_q == PTW_REFILL) && !req_data;
    assign itlb_refill.vpn       = req_vpn;
    assign itlb_refill.ppn       = walk_ppn;
    assign itlb_refill.superpage = walk_super;
    assign itlb_refill.perm_r    = walk_r;
    assign itlb_refill.perm_w    = walk_w;
    assign itlb_refill.perm_x    = walk_x;

    assign dtlb_refill.write     = (state_q == PTW_REFILL) && req_data;
    assign dtlb_refill.vpn       = req_vpn;
    assign dtlb_refill.ppn       = walk_ppn;
    assign dtlb_refill.superpage = walk_super;
    assign dtlb_refill.perm_r    = walk_r;
    assign dtlb_refill.perm_w    = walk_w;
    assign dtlb_refill.perm_x    = walk_x;

endmodule

`default_nettype wire

// ==== logic/tlb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlb import mmu_pkg::*; #(
    parameter int TLB_ENTRIES = 4
) (
    input  logic            clk,
    input  logic            arst_n_i,
    tlb_lookup_if.responder lookup_if,
    tlb_refill_if.reader    refill_if
);

    localparam int IDX_W    = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;
    // Low vpn bits ignored for a 4 MiB superpage
    localparam int VPN_LO_W = VPN_W / 2;

    tlb_entry_t             entries [TLB_ENTRIES];
    logic [IDX_W-1:0]       rr_ptr;
    logic [TLB_ENTRIES-1:0] entry_match;

    always_comb begin
        for (int k = 0; k < TLB_ENTRIES; k++) begin
            entry_match[k] = entries[k].valid
                && (entries[k].vpn[VPN_W-1:VPN_LO_W] == lookup_if.vpn[VPN_W-1:VPN_LO_W])
                && (entries[k].superpage
                    || (entries[k].vpn[VPN_LO_W-1:0] == lookup_if.vpn[VPN_LO_W-1:0]));
        end
    end

    // First matching entry wins; at most one should match anyway
    always_comb begin
        lookup_if.hit       = 1'b0;
        lookup_if.ppn       = '0;
        lookup_if.superpage = 1'b0;
        lookup_if.perm_r    = 1'b0;
        lookup_if.perm_w    = 1'b0;
        lookup_if.perm_x    = 1'b0;
        for (int k = 0; k < TLB_ENTRIES; k++) begin
            if (lookup_if.req && !lookup_if.hit && entry_match[k]) begin
                lookup_if.hit       = 1'b1;
                lookup_if.ppn       = entries[k].ppn;
                lookup_if.superpage = entries[k].superpage;
                lookup_if.perm_r    = entries[k].r;
                lookup_if.perm_w    = entries[k].w;
                lookup_if.perm_x    = entries[k].x;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            entries <= '{default: '0};
            rr_ptr  <= '0;
        end else if (lookup_if.flush) begin
            // Flush wins over a refill in the same cycle
            for (int k = 0; k < TLB_ENTRIES; k++) begin
                entries[k].valid <= 1'b0;
            end
            rr_ptr <= '0;
        end else if (refill_if.write) begin
            entries[rr_ptr] <= '{valid:     1'b1,
                                 vpn:       refill_if.vpn,
                                 superpage: refill_if.superpage,
                                 ppn:       refill_if.ppn,
                                 r:         refill_if.perm_r,
                                 w:         refill_if.perm_w,
                                 x:         refill_if.perm_x};
            if (rr_ptr == IDX_W'(TLB_ENTRIES - 1)) begin
                rr_ptr <= '0;
            end else begin
                rr_ptr <= rr_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_mmu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mmu import mmu_pkg::*; ();

    localparam int TLB_ENTRIES  = 4;
    localparam int MEM_CREDITS  = 2;
    localparam int MEM_LATENCY  = 3;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int DRIVE_DELAY  = 1;
    // 18 accesses plus flushes and the credit drain fit well inside this budget
    localparam int N_ACCESSES     = 20;
    localparam int ACCESS_LIMIT   = 200;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_ACCESSES * ACCESS_LIMIT;
    localparam logic [PPN_W-1:0] ROOT_PPN = 22'd1;

    logic             clk;
    logic             arst_n;
    logic [PPN_W-1:0] satp_ppn;
    logic             i_xlate_en;
    logic             d_xlate_en;
    logic             tlb_flush;
    logic             i_req;
    logic [VA_W-1:0]  i_vaddr;
    logic [PA_W-1:0]  i_paddr;
    logic             i_hit;
    logic             i_fault;
    logic             d_req;
    logic             d_store;
    logic [VA_W-1:0]  d_vaddr;
    logic [PA_W-1:0]  d_paddr;
    logic             d_hit;
    logic             d_fault;
    logic             mem_req;
    logic [PA_W-1:0]  mem_addr;
    logic             mem_rsp;
    logic [31:0]      mem_rdata;
    logic             mem_credit;
    int               credit_delay;
    int               read_count;
    int               outstanding;

    logic [31:0]      lfsr_state = 32'ha478;
    logic [VA_W-1:0]  va_a, va_b, va_c, va_d, va_e;
    logic [PPN_W-1:0] ppn_a, ppn_b, ppn_e;
    logic [PA_W-1:0]  read_addrs [$];
    int               cycle_count = 0;
    int               peak_outstanding = 0;
    int               checks = 0;
    int               errors = 0;
    int               tests_run = 0;
    int               tests_failed = 0;
    int               test_err_base;
    string            test_name;

    mmu #(.TLB_ENTRIES(TLB_ENTRIES), .MEM_CREDITS(MEM_CREDITS)) mmu_i (
        .clk          (clk),
        .arst_n_i     (arst_n),
        .satp_ppn_i   (satp_ppn),
        .i_xlate_en_i (i_xlate_en),
        .d_xlate_en_i (d_xlate_en),
        .tlb_flush_i  (tlb_flush),
        .i_req_i      (i_req),
        .i_vaddr_i    (i_vaddr),
        .i_paddr_o    (i_paddr),
        .i_hit_o      (i_hit),
        .i_fault_o    (i_fault),
        .d_req_i      (d_req),
        .d_store_i    (d_store),
        .d_vaddr_i    (d_vaddr),
        .d_paddr_o    (d_paddr),
        .d_hit_o      (d_hit),
        .d_fault_o    (d_fault),
        .mem_req_o    (mem_req),
        .mem_addr_o   (mem_addr),
        .mem_rsp_i    (mem_rsp),
        .mem_rdata_i  (mem_rdata),
        .mem_credit_i (mem_credit)
    );

    tb_pt_mem #(.MEM_LATENCY(MEM_LATENCY), .ADDR_W(PA_W)) pt_mem_i (
        .clk            (clk),
        .arst_n_i       (arst_n),
        .mem_req_i      (mem_req),
        .mem_addr_i     (mem_addr),
        .mem_rsp_o      (mem_rsp),
        .mem_rdata_o    (mem_rdata),
        .mem_credit_o   (mem_credit),
        .credit_delay_i (credit_delay),
        .read_count_o   (read_count),
        .outstanding_o  (outstanding)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (outstanding > peak_outstanding) begin
            peak_outstanding = outstanding;
        end
        if (mem_req) begin
            read_addrs.push_back(mem_addr);
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // Region selects a distinct root index for every mapping
    function automatic logic [VA_W-1:0] random_va(input logic [2:0] region);
        logic [6:0]  vpn1_lo;
        logic [9:0]  vpn0;
        logic [11:0] offset;
        vpn1_lo = 7'(lfsr_bits(7));
        vpn0    = 10'(lfsr_bits(10));
        offset  = 12'(lfsr_bits(12));
        return {region, vpn1_lo, vpn0, offset};
    endfunction

    function automatic pte_t make_pte(input logic [PPN_W-1:0] ppn, input logic [3:0] xwrv);
        pte_t p;
        p     = '0;
        p.ppn = ppn;
        p.x   = xwrv[3];
        p.w   = xwrv[2];
        p.r   = xwrv[1];
        p.v   = xwrv[0];
        return p;
    endfunction

    task automatic map_page(input logic [VA_W-1:0] va, input logic [PPN_W-1:0] l0_table,
                            input logic [PPN_W-1:0] ppn, input logic [3:0] xwrv);
        // Pointer entry has only v set
        pt_mem_i.store_word({ROOT_PPN, va[31:22], 2'b00}, make_pte(l0_table, 4'b0001));
        pt_mem_i.store_word({l0_table, va[21:12], 2'b00}, make_pte(ppn, xwrv));
    endtask

    task automatic build_page_tables();
        va_a  = random_va(3'd1);
        ppn_a = 22'(lfsr_bits(22));
        map_page(va_a, 22'd2, ppn_a, 4'b1011);
        va_b  = random_va(3'd2);
        ppn_b = {12'(lfsr_bits(12)), 10'd0};
        // Readable level-one leaf
        pt_mem_i.store_word({ROOT_PPN, va_b[31:22], 2'b00}, make_pte(ppn_b, 4'b0011));
        va_c = random_va(3'd3);
        map_page(va_c, 22'd3, 22'(lfsr_bits(22)), 4'b0011);
        va_d = random_va(3'd4);
        map_page(va_d, 22'd4, 22'(lfsr_bits(22)), 4'b1010);
        va_e  = random_va(3'd5);
        ppn_e = 22'(lfsr_bits(22));
        map_page(va_e, 22'd5, ppn_e, 4'b0111);
    endtask

    task automatic check_paddr(input logic [PA_W-1:0] got, input logic [PA_W-1:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input bit got, input bit exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("mismatch at %0t: %s got %0b, expected %0b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("mismatch at %0t: %s got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        test_err_base = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == test_err_base) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - test_err_base);
        end
    endtask

    // Holds the request until hit or fault like a core
    task automatic translate(input bit data_side, input bit store, input logic [VA_W-1:0] va,
                             output logic [PA_W-1:0] pa, output bit hit, output bit fault,
                             output int cycles);
        @(posedge clk);
        #DRIVE_DELAY;
        if (data_side) begin
            d_req   = 1'b1;
            d_store = store;
            d_vaddr = va;
        end else begin
            i_req   = 1'b1;
            i_vaddr = va;
        end
        cycles = 0;
        hit    = 1'b0;
        fault  = 1'b0;
        while (!hit && !fault) begin
            @(negedge clk);
            cycles++;
            hit   = data_side ? d_hit : i_hit;
            fault = data_side ? d_fault : i_fault;
        end
        pa = data_side ? d_paddr : i_paddr;
        @(posedge clk);
        #DRIVE_DELAY;
        i_req   = 1'b0;
        d_req   = 1'b0;
        d_store = 1'b0;
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        #DRIVE_DELAY;
        tlb_flush = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        tlb_flush = 1'b0;
    endtask

    task automatic bare_mode_test();
        logic [VA_W-1:0] iva, dva;
        int              reads0;
        start_test("bare mode");
        reads0 = read_count;
        repeat (8) begin
            iva = lfsr_bits(32);
            dva = lfsr_bits(32);
            @(posedge clk);
            #DRIVE_DELAY;
            i_req   = 1'b1;
            i_vaddr = iva;
            d_req   = 1'b1;
            d_vaddr = dva;
            @(negedge clk);
            check_flag(i_hit, 1'b1, "bare fetch hit");
            check_flag(d_hit, 1'b1, "bare data hit");
            check_paddr(i_paddr, {2'b00, iva}, "bare fetch paddr");
            check_paddr(d_paddr, {2'b00, dva}, "bare data paddr");
        end
        @(posedge clk);
        #DRIVE_DELAY;
        i_req = 1'b0;
        d_req = 1'b0;
        @(negedge clk);
        check_flag(i_hit, 1'b0, "bare fetch hit without request");
        check_flag(d_hit, 1'b0, "bare data hit without request");
        check_count(read_count - reads0, 0, "memory reads in bare mode");
        end_test();
    endtask

    task automatic page_walk_test();
        logic [PA_W-1:0] pa;
        logic [VA_W-1:0] va;
        bit              hit, fault;
        int              cycles, reads0;
        start_test("4 KiB walk");
        reads0 = read_count;
        read_addrs.delete();
        translate(1'b0, 1'b0, va_a, pa, hit, fault, cycles);
        check_flag(hit, 1'b1, "fetch hit after walk");
        check_paddr(pa, {ppn_a, va_a[11:0]}, "fetch paddr after walk");
        check_count(read_count - reads0, 2, "reads for a 4 KiB walk");
        check_paddr(read_addrs[0], {ROOT_PPN, va_a[31:22], 2'b00}, "level-one entry address");
        check_paddr(read_addrs[1], {22'd2, va_a[21:12], 2'b00}, "level-zero entry address");
        // Same page at another offset
        va     = {va_a[31:12], 12'(lfsr_bits(12))};
        reads0 = read_count;
        translate(1'b0, 1'b0, va, pa, hit, fault, cycles);
        check_flag(hit, 1'b1, "cached fetch hit");
        check_paddr(pa, {ppn_a, va[11:0]}, "cached fetch paddr");
        check_count(cycles, 1, "cycles for a TLB hit");
        check_count(read_count - reads0, 0, "reads for a TLB hit");
        end_test();
    endtask

    task automatic superpage_test();
        logic [PA_W-1:0] pa;
        bit              hit, fault;
        int              cycles, reads0;
        start_test("superpage");
        reads0 = read_count;
        read_addrs.delete();
        translate(1'b1, 1'b0, va_b, pa, hit, fault, cycles);
        check_flag(hit, 1'b1, "load hit on superpage");
        check_paddr(pa, {ppn_b[21:10], va_b[21:0]}, "superpage paddr");
        check_count(read_count - reads0, 1, "reads for a superpage walk");
        check_paddr(read_addrs[0], {ROOT_PPN, va_b[31:22], 2'b00}, "superpage entry address");
        end_test();
    endtask

    task automatic fault_test();
        logic [PA_W-1:0] pa;
        bit              hit, fault;
        int              cycles, reads0;
        start_test("faults");
        reads0 = read_count;
        translate(1'b1, 1'b1, va_c, pa, hit, fault, cycles);
        check_flag(fault, 1'b1, "store fault on read-only page");
        check_flag(hit, 1'b0, "store hit on read-only page");
        check_count(read_count - reads0, 2, "reads for a faulting store");
        // A load walks again only if the store left no refill
        reads0 = read_count;
        translate(1'b1, 1'b0, va_c, pa, hit, fault, cycles);
        check_flag(hit, 1'b1, "load hit on read-only page");
        check_count(read_count - reads0, 2, "reads for a load after a store fault");
        // Repeat shows that no refill was written
        repeat (2) begin
            reads0 = read_count;
            translate(1'b0, 1'b0, va_d, pa, hit, fault, cycles);
            check_flag(fault, 1'b1, "fetch fault on invalid page");
            check_flag(hit, 1'b0, "fetch hit on invalid page");
            check_count(read_count - reads0, 2, "reads for a faulting fetch");
        end
        end_test();
    endtask

    task automatic flush_test();
        logic [PA_W-1:0] pa;
        bit              hit, fault;
        int              cycles, reads0;
        start_test("flush");
        pulse_flush();
        reads0 = read_count;
        translate(1'b0, 1'b0, va_a, pa, hit, fault, cycles);
        check_flag(hit, 1'b1, "fetch hit after flush");
        check_paddr(pa, {ppn_a, va_a[11:0]}, "fetch paddr after flush");
        check_count(read_count - reads0, 2, "reads after flush");
        end_test();
    endtask

    task automatic credit_test();
        logic [PA_W-1:0] pa;
        bit              hit, fault;
        int              cycles, reads0;
        start_test("credits");
        @(posedge clk);
        #DRIVE_DELAY;
        credit_delay = 30;
        reads0 = read_count;
        translate(1'b1, 1'b1, va_e, pa, hit, fault, cycles);
        check_flag(hit, 1'b1, "store hit with slow credits");
        check_paddr(pa, {ppn_e, va_e[11:0]}, "store paddr with slow credits");
        // Next walk starts with no credit left
        pulse_flush();
        translate(1'b0, 1'b0, va_a, pa, hit, fault, cycles);
        check_flag(hit, 1'b1, "fetch hit after credit stall");
        check_paddr(pa, {ppn_a, va_a[11:0]}, "fetch paddr after credit stall");
        check_count(read_count - reads0, 4, "reads for two walks");
        check_count(peak_outstanding, MEM_CREDITS, "peak outstanding reads");
        credit_delay = 0;
        while (outstanding != 0) begin
            @(negedge clk);
        end
        end_test();
    endtask

    initial begin
        arst_n       = 1'b0;
        satp_ppn     = ROOT_PPN;
        i_xlate_en   = 1'b0;
        d_xlate_en   = 1'b0;
        tlb_flush    = 1'b0;
        i_req        = 1'b0;
        i_vaddr      = '0;
        d_req        = 1'b0;
        d_store      = 1'b0;
        d_vaddr      = '0;
        credit_delay = 0;
        @(posedge clk);
        build_page_tables();
        repeat (RESET_CYCLES - 1) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;
        bare_mode_test();
        @(posedge clk);
        #DRIVE_DELAY;
        i_xlate_en = 1'b1;
        d_xlate_en = 1'b1;
        page_walk_test();
        superpage_test();
        fault_test();
        flush_test();
        credit_test();
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/tb_pt_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pt_mem #(
    parameter int MEM_LATENCY = 3,
    parameter int ADDR_W      = 34
) (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              mem_req_i,
    input  logic [ADDR_W-1:0] mem_addr_i,
    output logic              mem_rsp_o,
    output logic [31:0]       mem_rdata_o,
    output logic              mem_credit_o,
    input  int                credit_delay_i,
    output int                read_count_o,
    output int                outstanding_o
);

    // Addresses above the 32 KiB window alias
    localparam int MEM_WORDS = 8192;

    logic [31:0] words [MEM_WORDS];
    int          cycle;
    int          reads;
    int          outstanding;
    int          rsp_due [$];
    logic [12:0] rsp_idx [$];
    int          credit_due [$];

    // Unwritten words read as invalid entries
    initial begin
        words = '{default: '0};
    end

    task automatic store_word(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
        words[addr[14:2]] = data;
    endtask

    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cycle       = 0;
            reads       = 0;
            outstanding = 0;
            rsp_due.delete();
            rsp_idx.delete();
            credit_due.delete();
            mem_rsp_o    <= 1'b0;
            mem_rdata_o  <= '0;
            mem_credit_o <= 1'b0;
        end else begin
            cycle = cycle + 1;
            mem_rsp_o    <= 1'b0;
            mem_credit_o <= 1'b0;
            // Fixed latency keeps responses in request order
            if (rsp_due.size() > 0 && rsp_due[0] == cycle) begin
                mem_rsp_o   <= 1'b1;
                mem_rdata_o <= words[rsp_idx[0]];
                credit_due.push_back(cycle + credit_delay_i);
                void'(rsp_due.pop_front());
                void'(rsp_idx.pop_front());
            end
            // At most one credit per cycle
            if (credit_due.size() > 0 && credit_due[0] <= cycle) begin
                mem_credit_o <= 1'b1;
                outstanding = outstanding - 1;
                void'(credit_due.pop_front());
            end
            if (mem_req_i) begin
                rsp_due.push_back(cycle + MEM_LATENCY);
                rsp_idx.push_back(mem_addr_i[14:2]);
                reads       = reads + 1;
                outstanding = outstanding + 1;
            end
        end
    end

    assign read_count_o  = reads;
    assign outstanding_o = outstanding;

endmodule

`default_nettype wire
